/* exec_params.svh */
// execute stage widths and pipeline depth, shared by the package and the units
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data path
`define XLEN 32

// rename tags
`define PRF_WIDTH 6 // physical register number
`define ROB_WIDTH 5 // reorder buffer entry

// multiplier register stages after dispatch
`define MUL_STAGES 4

// instruction field widths
`define FUNCT3_WIDTH 3

`endif

/* exec_pkg.sv */
// shared types for the execute stage: unit selects, opcodes, packets and result buses
`include "exec_params.svh"

package exec_pkg;

	typedef enum logic [1:0] {FU_ALU, FU_MUL, FU_BR, FU_MEM} fu_type_e;

	typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU} alu_op_e;

	typedef enum logic [1:0] {MUL, MULH, MULHSU, MULHU} mul_op_e;

	// one instruction word, decoded as I-type or S-type
	typedef union packed {
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [`FUNCT3_WIDTH-1:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_view;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [`FUNCT3_WIDTH-1:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_view;
	} inst_word_u;

	typedef struct packed {
		logic valid;
		fu_type_e fu_type;
		alu_op_e alu_op;
		mul_op_e mul_op;
		inst_word_u inst;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] npc;
		logic [`XLEN-1:0] op1;
		logic [`XLEN-1:0] op2;
		logic [`XLEN-1:0] imm; // branch offset, already sign extended
		logic rd_mem;
		logic wr_mem;
		logic cond_branch;
		logic uncond_branch;
		logic [`ROB_WIDTH-1:0] rob_entry;
		logic [`PRF_WIDTH-1:0] dest_prn;
	} issue_pkt_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] result;
		logic [`PRF_WIDTH-1:0] dest_prn;
		logic [`ROB_WIDTH-1:0] rob_entry;
	} cdb_pkt_t;

	typedef struct packed {
		logic valid; // link write, jumps only
		logic taken;
		logic cond_branch;
		logic uncond_branch;
		logic [`XLEN-1:0] target;
		logic [`XLEN-1:0] link;
		logic [`PRF_WIDTH-1:0] dest_prn;
		logic [`ROB_WIDTH-1:0] rob_entry;
	} branch_res_t;

	typedef struct packed {
		logic en;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] data;
		logic [`ROB_WIDTH-1:0] rob_entry;
	} store_req_t;

	typedef struct packed {
		logic en;
		logic [`XLEN-1:0] addr;
		logic [`FUNCT3_WIDTH-1:0] size;
	} load_req_t;

endpackage

/* issue_dispatch.sv */
// dispatch register: holds the issued packet and raises one go strobe per unit
`timescale 1ns/1ps

module issue_dispatch import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input issue_pkt_t issue,
	output issue_pkt_t disp_pkt,
	output logic alu_go,
	output logic mul_go,
	output logic br_go,
	output logic mem_go
);

	// payload follows the issuer every cycle, only valid is cleared
	always_ff @(posedge clk) begin
		disp_pkt <= issue;
		if (rst) begin
			disp_pkt.valid <= 1'b0;
		end
	end

	// unit select from the registered packet
	always_comb begin
		alu_go = 1'b0;
		mul_go = 1'b0;
		br_go = 1'b0;
		mem_go = 1'b0;
		if (disp_pkt.valid) begin
			case (disp_pkt.fu_type)
				FU_ALU: alu_go = 1'b1;
				FU_MUL: mul_go = 1'b1;
				FU_BR: br_go = 1'b1;
				FU_MEM: mem_go = 1'b1;
			endcase
		end
	end

endmodule

/* int_alu.sv */
// integer ALU, one operation per cycle with a registered CDB result
`timescale 1ns/1ps
`include "exec_params.svh"

module int_alu import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic go,
	input issue_pkt_t pkt,
	output cdb_pkt_t cdb
);

	logic [`XLEN-1:0] result;
	logic [4:0] shamt;

	assign shamt = pkt.op2[4:0]; // rv32 shift amount

	always_comb begin
		case (pkt.alu_op)
			ADD: result = pkt.op1 + pkt.op2;
			SUB: result = pkt.op1 - pkt.op2;
			AND: result = pkt.op1 & pkt.op2;
			OR: result = pkt.op1 | pkt.op2;
			XOR: result = pkt.op1 ^ pkt.op2;
			SLL: result = pkt.op1 << shamt;
			SRL: result = pkt.op1 >> shamt;
			SRA: result = $signed(pkt.op1) >>> shamt; // keeps the sign bit
			SLT: result = {{(`XLEN-1){1'b0}}, $signed(pkt.op1) < $signed(pkt.op2)};
			SLTU: result = {{(`XLEN-1){1'b0}}, pkt.op1 < pkt.op2};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		cdb.result <= result;
		cdb.dest_prn <= pkt.dest_prn;
		cdb.rob_entry <= pkt.rob_entry;
		if (rst) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= go;
		end
	end

endmodule

/* branch_unit.sv */
// branch resolution: condition, taken flag, target and link address
`timescale 1ns/1ps
`include "exec_params.svh"

module branch_unit import exec_pkg::*; (
	input logic go,
	input issue_pkt_t pkt,
	output branch_res_t res
);

	logic cond_true;
	logic [`FUNCT3_WIDTH-1:0] funct3;

	assign funct3 = pkt.inst.i_view.funct3;

	always_comb begin
		case (funct3)
			3'b000: cond_true = (pkt.op1 == pkt.op2); // beq
			3'b001: cond_true = (pkt.op1 != pkt.op2); // bne
			3'b100: cond_true = ($signed(pkt.op1) < $signed(pkt.op2)); // blt
			3'b101: cond_true = ($signed(pkt.op1) >= $signed(pkt.op2)); // bge
			3'b110: cond_true = (pkt.op1 < pkt.op2); // bltu
			3'b111: cond_true = (pkt.op1 >= pkt.op2); // bgeu
			default: cond_true = 1'b0;
		endcase
	end

	always_comb begin
		res.cond_branch = go & pkt.cond_branch;
		res.uncond_branch = go & pkt.uncond_branch;
		res.taken = go & (pkt.uncond_branch | (pkt.cond_branch & cond_true));
		res.target = res.taken ? pkt.pc + pkt.imm : '0;
		res.link = pkt.npc;
		res.valid = go & pkt.uncond_branch; // only jumps write rd
		res.dest_prn = pkt.dest_prn;
		res.rob_entry = pkt.rob_entry;
	end

endmodule

/* mul_pipe.sv */
// pipelined multiplier, accepts one product per cycle and carries its tags along
`timescale 1ns/1ps
`include "exec_params.svh"

module mul_pipe import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic go,
	input issue_pkt_t pkt,
	output cdb_pkt_t cdb
);

	typedef struct packed {
		logic valid;
		mul_op_e op;
		logic [2*`XLEN-1:0] prod;
		logic [`PRF_WIDTH-1:0] dest_prn;
		logic [`ROB_WIDTH-1:0] rob_entry;
	} mul_stage_t;

	mul_stage_t stage [`MUL_STAGES];
	mul_stage_t last;
	logic a_signed;
	logic b_signed;
	logic [`XLEN:0] a_ext;
	logic [`XLEN:0] b_ext;
	logic signed [2*`XLEN-1:0] prod;

	// mulhsu takes rs1 signed and rs2 unsigned
	assign a_signed = (pkt.mul_op != MULHU);
	assign b_signed = (pkt.mul_op == MUL) || (pkt.mul_op == MULH);
	assign a_ext = {a_signed & pkt.op1[`XLEN-1], pkt.op1};
	assign b_ext = {b_signed & pkt.op2[`XLEN-1], pkt.op2};
	assign prod = $signed({{(`XLEN-1){a_ext[`XLEN]}}, a_ext})
		* $signed({{(`XLEN-1){b_ext[`XLEN]}}, b_ext}); // 33-bit sign fills the top

	always_ff @(posedge clk) begin
		stage[0].op <= pkt.mul_op;
		stage[0].prod <= prod;
		stage[0].dest_prn <= pkt.dest_prn;
		stage[0].rob_entry <= pkt.rob_entry;
		for (int i = 1; i < `MUL_STAGES; i++) begin
			stage[i] <= stage[i-1]; // shift the whole record
		end
		if (rst) begin
			for (int i = 0; i < `MUL_STAGES; i++) begin
				stage[i].valid <= 1'b0;
			end
		end else begin
			stage[0].valid <= go;
		end
	end

	assign last = stage[`MUL_STAGES-1];

	always_comb begin
		cdb.valid = last.valid;
		cdb.result = (last.op == MUL) ? last.prod[`XLEN-1:0] : last.prod[2*`XLEN-1:`XLEN];
		cdb.dest_prn = last.dest_prn;
		cdb.rob_entry = last.rob_entry;
	end

endmodule

/* load_store_unit.sv */
// load/store unit: address generation, store and load requests, miss hold
`timescale 1ns/1ps
`include "exec_params.svh"

module load_store_unit import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic go,
	input issue_pkt_t pkt,
	input logic [`XLEN-1:0] load_data,
	input logic load_data_valid,
	output store_req_t store_req,
	output load_req_t load_req,
	output cdb_pkt_t mem_cdb,
	output logic miss_waiting
);

	logic ld_now;
	logic st_now;
	logic [11:0] imm_i;
	logic [11:0] imm_s;
	logic [`XLEN-1:0] addr_i;
	logic [`XLEN-1:0] addr_s;
	logic [`XLEN-1:0] held_addr;
	logic [`FUNCT3_WIDTH-1:0] held_size;
	logic [`PRF_WIDTH-1:0] held_prn;
	logic [`ROB_WIDTH-1:0] held_rob;

	assign ld_now = go & pkt.rd_mem;
	assign st_now = go & pkt.wr_mem;

	// same word, two immediate layouts
	assign imm_i = pkt.inst.i_view.imm;
	assign imm_s = {pkt.inst.s_view.imm_hi, pkt.inst.s_view.imm_lo};
	assign addr_i = pkt.op1 + {{(`XLEN-12){imm_i[11]}}, imm_i};
	assign addr_s = pkt.op1 + {{(`XLEN-12){imm_s[11]}}, imm_s};

	always_comb begin
		store_req.en = st_now;
		store_req.addr = addr_s;
		store_req.data = pkt.op2;
		store_req.rob_entry = pkt.rob_entry;
	end

	// while a miss is pending the request repeats the held load
	always_comb begin
		load_req.en = miss_waiting | ld_now;
		load_req.addr = miss_waiting ? held_addr : addr_i;
		load_req.size = miss_waiting ? held_size : pkt.inst.i_view.funct3;
	end

	always_comb begin
		mem_cdb.valid = load_data_valid & (miss_waiting | ld_now);
		mem_cdb.result = load_data;
		mem_cdb.dest_prn = miss_waiting ? held_prn : pkt.dest_prn;
		mem_cdb.rob_entry = miss_waiting ? held_rob : pkt.rob_entry;
	end

	always_ff @(posedge clk) begin
		if (ld_now && !load_data_valid) begin // miss, keep the load
			held_addr <= addr_i;
			held_size <= pkt.inst.i_view.funct3;
			held_prn <= pkt.dest_prn;
			held_rob <= pkt.rob_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			miss_waiting <= 1'b0;
		end else if (ld_now && !load_data_valid) begin
			miss_waiting <= 1'b1;
		end else if (load_data_valid) begin
			miss_waiting <= 1'b0; // data returned on the cdb this cycle
		end
	end

endmodule

/* exec_top.sv */
// execute stage top: dispatch register feeding ALU, branch, multiplier and load/store
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_top import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input issue_pkt_t issue,
	input logic [`XLEN-1:0] load_data,
	input logic load_data_valid,
	output cdb_pkt_t alu_cdb,
	output cdb_pkt_t mul_cdb,
	output cdb_pkt_t mem_cdb,
	output branch_res_t br_res,
	output store_req_t store_req,
	output load_req_t load_req,
	output logic miss_waiting
);

	issue_pkt_t disp_pkt;
	logic alu_go;
	logic mul_go;
	logic br_go;
	logic mem_go;

	issue_dispatch issue_dispatch_inst (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.disp_pkt(disp_pkt),
		.alu_go(alu_go),
		.mul_go(mul_go),
		.br_go(br_go),
		.mem_go(mem_go)
	);

	int_alu int_alu_inst (
		.clk(clk),
		.rst(rst),
		.go(alu_go),
		.pkt(disp_pkt),
		.cdb(alu_cdb)
	);

	branch_unit branch_unit_inst (
		.go(br_go),
		.pkt(disp_pkt),
		.res(br_res)
	);

	mul_pipe mul_pipe_inst (
		.clk(clk),
		.rst(rst),
		.go(mul_go),
		.pkt(disp_pkt),
		.cdb(mul_cdb)
	);

	load_store_unit load_store_unit_inst (
		.clk(clk),
		.rst(rst),
		.go(mem_go),
		.pkt(disp_pkt),
		.load_data(load_data),
		.load_data_valid(load_data_valid),
		.store_req(store_req),
		.load_req(load_req),
		.mem_cdb(mem_cdb),
		.miss_waiting(miss_waiting)
	);

endmodule

/* tb_exec_model.svh */
// testbench model for the execute stage: LFSR source, reference results and compare tasks
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// galois lfsr, one step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
	end
	return v;
endfunction

function automatic logic br_taken(input issue_pkt_t p);
	logic [31:0] iw;
	logic [31:0] sa;
	logic [31:0] sb;
	logic c;
	iw = p.inst;
	sa = p.op1 ^ 32'h8000_0000; // sign flip turns signed order into unsigned
	sb = p.op2 ^ 32'h8000_0000;
	case (iw[14:12])
		3'b000: c = (p.op1 == p.op2);
		3'b001: c = (p.op1 != p.op2);
		3'b100: c = (sa < sb);
		3'b101: c = !(sa < sb);
		3'b110: c = (p.op1 < p.op2);
		3'b111: c = !(p.op1 < p.op2);
		default: c = 1'b0;
	endcase
	return p.uncond_branch | (p.cond_branch & c);
endfunction

// alu value, multiply word, branch target or memory address
function automatic logic [31:0] exp_result(input issue_pkt_t p);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] iw;
	logic [63:0] ea;
	logic [63:0] eb;
	logic [63:0] w;
	logic [11:0] off;
	a = p.op1;
	b = p.op2;
	iw = p.inst;
	exp_result = '0;
	case (p.fu_type)
		FU_ALU: begin
			case (p.alu_op)
				ADD: exp_result = a + b;
				SUB: exp_result = a + ~b + 32'd1;
				AND: exp_result = a & b;
				OR: exp_result = a | b;
				XOR: exp_result = a ^ b;
				SLL: exp_result = a << b[4:0];
				SRL: exp_result = a >> b[4:0];
				SRA: begin
					w = {{32{a[31]}}, a} >> b[4:0];
					exp_result = w[31:0];
				end
				SLT: exp_result = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
				SLTU: exp_result = {31'd0, a < b};
				default: exp_result = '0;
			endcase
		end
		FU_MUL: begin
			ea = (p.mul_op == MULHU) ? {32'd0, a} : {{32{a[31]}}, a};
			eb = (p.mul_op == MUL || p.mul_op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
			w = ea * eb; // product modulo 2^64 is the two's complement result
			exp_result = (p.mul_op == MUL) ? w[31:0] : w[63:32];
		end
		FU_BR: exp_result = br_taken(p) ? p.pc + p.imm : '0;
		default: begin
			off = p.wr_mem ? {iw[31:25], iw[11:7]} : iw[31:20]; // S or I immediate
			exp_result = a + {{20{off[11]}}, off};
		end
	endcase
endfunction

function automatic cdb_pkt_t make_cdb(input issue_pkt_t p, input logic [31:0] result);
	cdb_pkt_t c;
	c.valid = 1'b1;
	c.result = result;
	c.dest_prn = p.dest_prn;
	c.rob_entry = p.rob_entry;
	return c;
endfunction

function automatic branch_res_t make_branch(input issue_pkt_t p);
	branch_res_t r;
	r.valid = p.uncond_branch; // only jumps write the link
	r.taken = br_taken(p);
	r.cond_branch = p.cond_branch;
	r.uncond_branch = p.uncond_branch;
	r.target = exp_result(p);
	r.link = p.npc;
	r.dest_prn = p.dest_prn;
	r.rob_entry = p.rob_entry;
	return r;
endfunction

task automatic check_cdb(input string name, input cdb_pkt_t got, input cdb_pkt_t exp);
	if (got !== exp) begin
		fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_branch(input string name, input branch_res_t got, input branch_res_t exp);
	if (got !== exp) begin
		fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_store(input string name, input store_req_t got, input store_req_t exp);
	if (got !== exp) begin
		fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_load(input string name, input load_req_t got, input load_req_t exp);
	if (got !== exp) begin
		fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	end
endtask

`endif

/* tb_exec_top.sv */
// testbench for the execute stage: random issue stream, reference model and result compare
`timescale 1ns/1ps

module tb_exec_top import exec_pkg::*; ();

	localparam int N_ALU = 200;
	localparam int N_MUL = 40;
	localparam int N_BR = 60;
	localparam int N_ST = 30;
	localparam int N_LD = 30;
	localparam int WATCHDOG_CYCLES = (N_ALU + N_MUL + N_BR + N_ST + N_LD) * 20 + 8;

	logic clk = 1'b0;
	logic rst;
	issue_pkt_t issue;
	logic [31:0] load_data;
	logic load_data_valid;
	cdb_pkt_t alu_cdb;
	cdb_pkt_t mul_cdb;
	cdb_pkt_t mem_cdb;
	branch_res_t br_res;
	store_req_t store_req;
	load_req_t load_req;
	logic miss_waiting;

	logic [31:0] lfsr;
	int cyc = 0;
	logic ld_pending = 1'b0; // a load seen in an earlier cycle still waits for data
	load_req_t ld_cur;
	cdb_pkt_t alu_q[$];
	cdb_pkt_t mul_q[$];
	cdb_pkt_t mem_q[$];
	branch_res_t br_q[$];
	store_req_t st_q[$];
	load_req_t ld_q[$];
	int alu_due[$];
	int mul_due[$];
	int br_due[$];
	int st_due[$];
	int ld_due[$];

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic on_time(input string name, input int due);
		if (due != cyc) begin
			fail_run($sformatf("%s came in cycle %0d but was due in cycle %0d", name, cyc, due));
		end
	endtask

	`include "tb_exec_model.svh"

	exec_top exec_top_inst (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.load_data(load_data),
		.load_data_valid(load_data_valid),
		.alu_cdb(alu_cdb),
		.mul_cdb(mul_cdb),
		.mem_cdb(mem_cdb),
		.br_res(br_res),
		.store_req(store_req),
		.load_req(load_req),
		.miss_waiting(miss_waiting)
	);

	initial begin
		forever begin
			#10 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic issue_pkt_t rand_pkt(input fu_type_e fu, input logic is_load);
		issue_pkt_t p;
		logic [31:0] r;
		p = '0;
		p.valid = 1'b1;
		p.fu_type = fu;
		r = rand_bits(4);
		p.alu_op = alu_op_e'(r[3:0] % 4'd10);
		r = rand_bits(2);
		p.mul_op = mul_op_e'(r[1:0]);
		p.inst = rand_bits(32);
		r = rand_bits(30);
		p.pc = {r[29:0], 2'b00};
		p.npc = p.pc + 32'd4;
		p.op1 = rand_bits(32);
		p.op2 = rand_bits(32);
		r = rand_bits(12);
		p.imm = {{19{r[11]}}, r[11:0], 1'b0};
		r = rand_bits(2);
		p.cond_branch = (fu == FU_BR) & !r[0];
		p.uncond_branch = (fu == FU_BR) & r[0];
		if (fu == FU_BR && r[1]) begin
			p.op2 = p.op1; // equal operands now and then
		end
		if (p.inst.i_view.funct3[2:1] == 2'b01) begin
			p.inst.i_view.funct3[2] = 1'b1; // 2 and 3 are no branch codes
		end
		p.rd_mem = (fu == FU_MEM) & is_load;
		p.wr_mem = (fu == FU_MEM) & !is_load;
		r = rand_bits(5);
		p.rob_entry = r[4:0];
		r = rand_bits(6);
		p.dest_prn = r[5:0];
		return p;
	endfunction

	// drive one packet and queue what each unit should return
	task automatic send(input issue_pkt_t p);
		@(posedge clk);
		issue <= p;
		case (p.fu_type)
			FU_ALU: begin
				alu_q.push_back(make_cdb(p, exp_result(p)));
				alu_due.push_back(cyc + 3);
			end
			FU_MUL: begin
				mul_q.push_back(make_cdb(p, exp_result(p)));
				mul_due.push_back(cyc + 6); // dispatch plus four stages
			end
			FU_BR: begin
				br_q.push_back(make_branch(p));
				br_due.push_back(cyc + 2);
			end
			default: begin
				if (p.wr_mem) begin
					st_q.push_back({1'b1, exp_result(p), p.op2, p.rob_entry});
					st_due.push_back(cyc + 2);
				end else begin
					ld_q.push_back({1'b1, exp_result(p), p.inst.i_view.funct3});
					ld_due.push_back(cyc + 2);
				end
			end
		endcase
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			issue.valid <= 1'b0;
		end
	endtask

	// delay 0 is a hit, data comes in the request cycle
	task automatic do_load(input int delay);
		issue_pkt_t p;
		issue_pkt_t behind;
		logic [31:0] d;
		p = rand_pkt(FU_MEM, 1'b1);
		d = rand_bits(32);
		send(p);
		mem_q.push_back(make_cdb(p, d));
		behind = ~p; // other payload behind the load, only the held copy matches
		behind.valid = 1'b0;
		@(posedge clk);
		issue <= behind;
		load_data <= d;
		repeat (delay) begin
			@(posedge clk);
		end
		load_data_valid <= 1'b1;
		@(posedge clk);
		load_data_valid <= 1'b0;
	endtask

	initial begin
		issue_pkt_t p;
		logic [31:0] r;
		rst = 1'b1;
		issue = '1; // valid work for each unit in turn while reset holds
		load_data = '0;
		load_data_valid = 1'b0;
		lfsr = 32'h5438210c;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			issue.fu_type <= fu_type_e'(i[1:0]);
		end
		rst <= 1'b0;
		issue <= '0;
		idle(3);
		for (int i = 0; i < N_ALU; i++) begin
			send(rand_pkt(FU_ALU, 1'b0));
		end
		for (int i = 0; i < N_MUL; i++) begin
			p = rand_pkt(FU_MUL, 1'b0);
			p.mul_op = mul_op_e'(i[1:0]); // all four kinds in turn
			send(p);
		end
		for (int i = 0; i < N_BR; i++) begin
			send(rand_pkt(FU_BR, 1'b0));
		end
		for (int i = 0; i < N_ST; i++) begin
			send(rand_pkt(FU_MEM, 1'b0));
		end
		for (int i = 0; i < N_LD; i++) begin
			r = rand_bits(3);
			do_load(i[0] ? int'(r[2:0]) + 1 : 0); // hits and misses alternate
		end
		idle(12);
		if (alu_q.size() + mul_q.size() + br_q.size() + st_q.size() + ld_q.size()
				+ mem_q.size() == 0 && !ld_pending) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			fail_run("some expected results never came out of the DUT");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) begin
			@(posedge clk);
		end
		fail_run("timeout, the tests did not finish within the cycle budget");
	end

	// outputs are sampled mid cycle, away from the driving edge
	always @(negedge clk) begin
		if (rst && ({alu_cdb.valid, mul_cdb.valid, mem_cdb.valid, br_res.valid, br_res.taken,
				store_req.en, load_req.en, miss_waiting} !== 8'd0)) begin
			fail_run("an output is active while reset is asserted");
		end
		if (alu_cdb.valid) begin
			if (alu_q.size() == 0) begin
				fail_run("alu_cdb is valid with no ALU operation outstanding");
			end
			on_time("alu_cdb", alu_due.pop_front());
			check_cdb("alu_cdb", alu_cdb, alu_q.pop_front());
		end
		if (mul_cdb.valid) begin
			if (mul_q.size() == 0) begin
				fail_run("mul_cdb is valid with no multiply outstanding");
			end
			on_time("mul_cdb", mul_due.pop_front());
			check_cdb("mul_cdb", mul_cdb, mul_q.pop_front());
		end
		if (br_res.valid || br_res.taken || br_res.cond_branch || br_res.uncond_branch) begin
			if (br_q.size() == 0) begin
				fail_run("br_res is active with no branch outstanding");
			end
			on_time("br_res", br_due.pop_front());
			check_branch("br_res", br_res, br_q.pop_front());
		end
		if (store_req.en) begin
			if (st_q.size() == 0) begin
				fail_run("store_req is enabled with no store outstanding");
			end
			on_time("store_req", st_due.pop_front());
			check_store("store_req", store_req, st_q.pop_front());
		end
		if (miss_waiting !== ld_pending) begin
			fail_run($sformatf("mismatch miss_waiting: got %h expected %h", miss_waiting,
				ld_pending));
		end
		if (load_req.en) begin
			if (!ld_pending) begin // a new load, not a held one
				if (ld_q.size() == 0) begin
					fail_run("load_req is enabled with no load outstanding");
				end
				on_time("load_req", ld_due.pop_front());
				ld_cur = ld_q.pop_front();
			end
			check_load("load_req", load_req, ld_cur);
			if (mem_cdb.valid) begin
				check_cdb("mem_cdb", mem_cdb, mem_q.pop_front());
				ld_pending = 1'b0;
			end else begin
				ld_pending = 1'b1;
			end
		end else if (mem_cdb.valid) begin
			fail_run("mem_cdb is valid without a load request");
		end
	end

endmodule

/* files.f */
+incdir+.
exec_pkg.sv
issue_dispatch.sv
int_alu.sv
branch_unit.sv
mul_pipe.sv
load_store_unit.sv
exec_top.sv
tb_exec_top.sv

/* run_sim.sh */
#!/bin/sh
# build the execute stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_exec_top -f files.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_exec_top)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1
